/* sniff_input.txt */
# sniffer test records, one per line, applied in order
# columns: pattern level ticks noise expected
# pattern 0 steady carrier, 1 zero pause, 3 level hold,
# 2 load modulation square of period 16 between level and level - 80
# noise 1 adds -1, 0 or +1 to each sample
# expected is the first-frame byte in hex once settled, -- skips the record
#
# unmodulated carrier, reader bits 1, no tag activity
0 200 1024 0 F0
# tag load modulation without a reader pause
2 230 1024 1 FF
# long reader pause, deep modulation clears the tag nibble
1 0 640 0 00
# weak field inside the hysteresis band keeps reader_bit at 0
3 10 3200 0 00
# field loss fires during this record
3 10 1152 0 --
3 10 1024 0 F0
# carrier back, then a short pause before a second tag answer
0 200 768 0 F0
1 0 64 0 --
2 230 1024 1 FF

/* all.f */
iso14443a_rf_pkg.sv
sniff_frame_pkg.sv
carrier_frontend.sv
carrier_timebase.sv
tag_mod_detector.sv
sniff_packer.sv
ssp_sniff_tx.sv
hi_iso14443a_sniff.sv
hi_iso14443a_sniff_sva.sv
tb_hi_iso14443a_sniff.sv

/* tb_hi_iso14443a_sniff.sv */
/*
 * Testbench for the ISO14443-A sniffer. Records are read from sniff_input.txt,
 * so the run starts in the project root. A byte is compared only once its
 * record has settled, and never across a change of pattern.
 */
module tb_hi_iso14443a_sniff;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_records = 32;
	// deep_mod idle run plus one full byte period
	localparam int settle_ticks = 384;
	// clock and frame timing is exact until the first reader pause
	localparam int timing_ticks = 1024;
	localparam int frame_len = 64;
	localparam int timeout_margin = 512;

	logic adc_clk = 1'b0;
	logic fdt_reset;
	logic [7:0] adc_d;
	logic ssp_clk;
	logic ssp_frame;
	logic ssp_din;
	logic dbg;

	// ------------------------------
	// test records
	// ------------------------------
	int rec_code [max_records];
	int rec_level [max_records];
	int rec_ticks [max_records];
	int rec_noise [max_records];
	int rec_start [max_records];
	logic [7:0] rec_expect [max_records];
	logic rec_skip [max_records];
	int n_records;
	int total_ticks;

	int cyc;
	int reset_edges;
	int cycle_limit;
	int n_checks;
	int n_errors;
	int sva_fails;

	// SSP capture state
	logic clk_q;
	logic frame_q;
	int frames_seen;
	int frame_k;
	int bit_cnt;
	int k;
	int rec_idx;
	logic [7:0] cap_byte;
	logic [7:0] first_byte = 8'h00;

	hi_iso14443a_sniff hi_iso14443a_sniff_i (
		.adc_clk(adc_clk),
		.fdt_reset(fdt_reset),
		.adc_d(adc_d),
		.ssp_clk(ssp_clk),
		.ssp_frame(ssp_frame),
		.ssp_din(ssp_din),
		.dbg(dbg)
	);

	// 4 ns carrier sample clock
	always
	begin
		#2;
		adc_clk = ~adc_clk;
	end

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		n_checks++;
		if (got !== expected)
		begin
			n_errors++;
			$display("error %s: got %h, expected %h (cycle %0d)", name, got, expected, cyc);
		end
	endtask

	// sample n of a record, before noise
	function automatic logic [7:0] carrier_sample(input int code, input int level, input int idx);
		int value;
		case (code)
			1: value = 0;
			// 8 ticks at level, 8 ticks 80 lower
			2: value = ((idx / 8) % 2 == 0) ? level : level - 80;
			default: value = level;
		endcase
		return value[7:0];
	endfunction

	// record that fully covers the period before a frame, or -1
	function automatic int find_record(input int frame_tick);
		int found;
		found = -1;
		for (int r = 0; r < n_records; r++)
		begin
			if (frame_tick >= rec_start[r] + settle_ticks
				&& frame_tick <= rec_start[r] + rec_ticks[r])
				found = r;
		end
		return found;
	endfunction

	// cycle count after reset, also the run limit
	always @(posedge adc_clk)
	begin
		if (fdt_reset)
			reset_edges <= reset_edges + 1;
		else
			cyc <= cyc + 1;
		if (cycle_limit > 0 && cyc >= cycle_limit)
		begin
			$display("timeout: the SSP link did not deliver all frames within %0d cycles", cyc);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ------------------------------
	// SSP capture, on the falling edge
	// ------------------------------
	always @(negedge adc_clk)
	begin
		if (cyc == 0)
		begin
			// all SSP outputs held low by reset
			if (reset_edges > 0)
			begin
				check_value("ssp_clk", ssp_clk, 8'h00);
				check_value("ssp_frame", ssp_frame, 8'h00);
				check_value("ssp_din", ssp_din, 8'h00);
			end
		end
		else
		begin
			// k is the rising edge just before this sample point
			k = cyc - 1;
			if (k < timing_ticks)
			begin
				check_value("ssp_clk", ssp_clk, (k % 8) < 4);
				check_value("ssp_frame", ssp_frame, (k % 64) < 8);
				// timebase bit 3 after this edge
				check_value("dbg", dbg, ((k + 1) % 16) >= 8);
			end
			if (ssp_frame && !frame_q)
			begin
				frames_seen = frames_seen + 1;
				frame_k = k;
				bit_cnt = 0;
			end
			if (ssp_clk && !clk_q && frames_seen > 0)
			begin
				if (frames_seen % 2 == 1)
				begin
					// first frame of a period, MSB first
					cap_byte = {cap_byte[6:0], ssp_din};
					bit_cnt = bit_cnt + 1;
					if (bit_cnt == 8)
					begin
						first_byte = cap_byte;
						rec_idx = find_record(frame_k);
						if (rec_idx >= 0 && !rec_skip[rec_idx])
							check_value("ssp_din byte", cap_byte, rec_expect[rec_idx]);
					end
				end
				else
				begin
					// second frame repeats bit 0
					check_value("ssp_din", ssp_din, first_byte[0]);
				end
			end
		end
		clk_q = ssp_clk;
		frame_q = ssp_frame;
	end

	initial
	begin : main_flow
		int fd;
		int n;
		int seed;
		int code;
		int level;
		int ticks;
		int noise;
		int target_frames;
		int total_errors;
		string line;
		string exp_str;
		logic [7:0] value;

		fdt_reset = 1'b1;
		adc_d = 8'd200;
		seed = $urandom(32'haf3b0019);
		n_records = 0;
		total_ticks = 0;

		// ------------------------------
		// read the records
		// ------------------------------
		fd = $fopen("sniff_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open sniff_input.txt from the working directory");
			n_errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				n = $sscanf(line, "%d %d %d %d %s", code, level, ticks, noise, exp_str);
				if (line[0] != "#" && n == 5 && n_records < max_records)
				begin
					rec_code[n_records] = code;
					rec_level[n_records] = level;
					rec_ticks[n_records] = ticks;
					rec_noise[n_records] = noise;
					rec_start[n_records] = total_ticks;
					rec_skip[n_records] = (exp_str == "--");
					value = 8'h00;
					if (exp_str != "--")
						n = $sscanf(exp_str, "%h", value);
					rec_expect[n_records] = value;
					total_ticks = total_ticks + ticks;
					n_records++;
				end
			end
			$fclose(fd);
		end
		if (n_records == 0)
		begin
			$display("no test records were read, nothing to run");
			n_errors++;
		end
		cycle_limit = total_ticks + timeout_margin;

		// reset for 10 clock cycles
		repeat (10) @(negedge adc_clk);
		fdt_reset = 1'b0;

		// ------------------------------
		// carrier stimulus
		// ------------------------------
		for (int r = 0; r < n_records; r++)
		begin
			for (int i = 0; i < rec_ticks[r]; i++)
			begin
				value = carrier_sample(rec_code[r], rec_level[r], i);
				if (rec_noise[r] != 0)
					value = value + 8'($urandom % 3) - 8'd1;
				adc_d = value;
				@(negedge adc_clk);
			end
		end

		// one complete frame past the last record
		target_frames = total_ticks / frame_len + 2;
		while (frames_seen < target_frames)
			@(posedge adc_clk);

		sva_fails = hi_iso14443a_sniff_i.ssp_sniff_tx_i.ssp_checks_i.fail_count;
		total_errors = n_errors + sva_fails;
		$display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, sva_fails);
		if (total_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* hi_iso14443a_sniff_sva.sv */
/*
 * SSP framing assertions, bound into every ssp_sniff_tx.
 * Sampled on the rising edge of adc_clk, like the transmitter itself.
 */
module ssp_framing_checks
(
	input logic adc_clk,
	input logic fdt_reset,
	input logic ssp_clk,
	input logic ssp_frame,
	input logic ssp_din
);

	timeunit 1ns;
	timeprecision 100ps;

	// failure counts, summed for the end of the run
	int frame_fails = 0;
	int din_fails = 0;
	int reset_fails = 0;
	int fail_count;

	assign fail_count = frame_fails + din_fails + reset_fails;

	// a frame starts on the first bit clock of that frame
	frame_on_clk: assert property (@(posedge adc_clk) disable iff (fdt_reset)
		$rose(ssp_frame) |-> $rose(ssp_clk))
	else
	begin
		frame_fails++;
		$error("ssp_frame rose without a rising ssp_clk");
	end

	// host samples on the rising clock, data moves only there
	din_on_clk: assert property (@(posedge adc_clk) disable iff (fdt_reset)
		$changed(ssp_din) |-> $rose(ssp_clk))
	else
	begin
		din_fails++;
		$error("ssp_din changed away from a rising ssp_clk");
	end

	quiet_in_reset: assert property (@(posedge adc_clk)
		fdt_reset |=> (!ssp_clk && !ssp_frame && !ssp_din))
	else
	begin
		reset_fails++;
		$error("SSP output high during reset");
	end

endmodule

bind ssp_sniff_tx ssp_framing_checks ssp_checks_i (
	.adc_clk(adc_clk),
	.fdt_reset(fdt_reset),
	.ssp_clk(ssp_clk),
	.ssp_frame(ssp_frame),
	.ssp_din(ssp_din)
);

/* hi_iso14443a_sniff.sv */
/*
 * ISO14443-A sniffer top level, runs on the rising edge of adc_clk.
 * Sniffer path only, no tag simulation and no antenna drive.
 */
module hi_iso14443a_sniff
	import iso14443a_rf_pkg::*;
	import sniff_frame_pkg::*;
(
	input logic adc_clk,
	input logic fdt_reset,
	input adc_sample_t adc_d,
	output logic ssp_clk,
	output logic ssp_frame,
	output logic ssp_din,
	output logic dbg
);

	rf_status_t rf_status;
	tick_t tick;
	logic tag_bit;
	sniff_byte_t sniff_byte;
	logic byte_load;

	// reader demodulation
	carrier_frontend carrier_frontend_i (
		.adc_clk(adc_clk),
		.fdt_reset(fdt_reset),
		.adc_d(adc_d),
		.rf_status(rf_status)
	);

	carrier_timebase carrier_timebase_i (
		.adc_clk(adc_clk),
		.fdt_reset(fdt_reset),
		.rf_status(rf_status),
		.tick(tick)
	);

	// tag answer detection
	tag_mod_detector tag_mod_detector_i (
		.adc_clk(adc_clk),
		.fdt_reset(fdt_reset),
		.adc_d(adc_d),
		.rf_status(rf_status),
		.tick(tick),
		.tag_bit(tag_bit)
	);

	sniff_packer sniff_packer_i (
		.adc_clk(adc_clk),
		.fdt_reset(fdt_reset),
		.rf_status(rf_status),
		.tag_bit(tag_bit),
		.tick(tick),
		.sniff_byte(sniff_byte),
		.byte_load(byte_load)
	);

	// host link
	ssp_sniff_tx ssp_sniff_tx_i (
		.adc_clk(adc_clk),
		.fdt_reset(fdt_reset),
		.tick(tick),
		.sniff_byte(sniff_byte),
		.byte_load(byte_load),
		.ssp_clk(ssp_clk),
		.ssp_frame(ssp_frame),
		.ssp_din(ssp_din)
	);

	// toggles every 8 ticks, shows the timebase on a scope
	assign dbg = tick[3];

endmodule

/* ssp_sniff_tx.sv */
/*
 * SSP transmitter to the host, no back-pressure.
 * ssp_clk is adc_clk / 8, ssp_frame marks each 64-tick frame.
 * Second frame of a period repeats bit 0 of the byte.
 */
module ssp_sniff_tx
	import sniff_frame_pkg::*;
(
	input logic adc_clk,
	input logic fdt_reset,
	input tick_t tick,
	input sniff_byte_t sniff_byte,
	input logic byte_load,
	output logic ssp_clk,
	output logic ssp_frame,
	output logic ssp_din
);

	localparam int bit_w = $clog2(bit_ticks);
	localparam int frame_w = $clog2(frame_ticks);

	logic [7:0] tx_shift;
	logic bit_start;
	logic frame_start;

	assign bit_start = (tick[bit_w-1:0] == '0);
	assign frame_start = (tick[frame_w-1:0] == '0);

	// ------------------------------
	// clock and frame
	// ------------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			ssp_clk <= 1'b0;
			ssp_frame <= 1'b0;
		end
		else
		begin
			// high for the first half of each bit
			if (bit_start)
				ssp_clk <= 1'b1;
			else if (tick[bit_w-1:0] == bit_w'(bit_ticks / 2))
				ssp_clk <= 1'b0;

			// rising edge of ssp_frame starts a frame
			if (frame_start)
				ssp_frame <= 1'b1;
			else if (tick[frame_w-1:0] == frame_w'(frame_high_ticks))
				ssp_frame <= 1'b0;
		end
	end

	// ------------------------------
	// serializer
	// ------------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			tx_shift <= '0;
		else if (byte_load)
			tx_shift <= sniff_byte;
		// MSB first, LSB is kept and fills from below
		else if (bit_start && !frame_start)
			tx_shift <= {tx_shift[6:0], tx_shift[0]};
	end

	assign ssp_din = tx_shift[7];

endmodule

/* sniff_packer.sv */
/*
 * Packs four reader and four tag bits into one byte per 128 ticks.
 * Tag bits read as zero while the reader is modulating.
 */
module sniff_packer
	import iso14443a_rf_pkg::*;
	import sniff_frame_pkg::*;
(
	input logic adc_clk,
	input logic fdt_reset,
	input rf_status_t rf_status,
	input logic tag_bit,
	input tick_t tick,
	output sniff_byte_t sniff_byte,
	output logic byte_load
);

	nibble_t reader_nib;
	nibble_t tag_nib;

	// ------------------------------
	// bit sampling
	// ------------------------------
	// newest bit enters at the LSB
	always_ff @(posedge adc_clk)
	begin
		if (tick[3:0] == sample_phase)
		begin
			reader_nib <= {reader_nib[2:0], rf_status.reader_bit};
			tag_nib <= {tag_nib[2:0], tag_bit};
		end
	end

	// ------------------------------
	// byte latch
	// ------------------------------
	always_ff @(posedge adc_clk)
	begin
		if (tick == load_tick)
		begin
			sniff_byte.reader_nib <= reader_nib;
			// reader is sending, or there is no field at all
			sniff_byte.tag_nib <= rf_status.deep_mod ? nibble_t'(0) : tag_nib;
		end
	end

	// strobe is valid together with the latched byte
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			byte_load <= 1'b0;
		else
			byte_load <= (tick == load_tick);
	end

endmodule

/* tag_mod_detector.sv */
/*
 * Tag load modulation detector for the sniffer.
 * Gaussian derivative over five samples, peak hold over one 16-tick bit.
 * Reset phase follows reader rising edges seen during deep modulation.
 */
module tag_mod_detector
	import iso14443a_rf_pkg::*;
	import sniff_frame_pkg::*;
(
	input logic adc_clk,
	input logic fdt_reset,
	input adc_sample_t adc_d,
	input rf_status_t rf_status,
	input tick_t tick,
	output logic tag_bit
);

	// sample history, prev_1 is one tick back
	adc_sample_t prev_1;
	adc_sample_t prev_2;
	adc_sample_t prev_3;
	adc_sample_t prev_4;

	filtered_t term_old;
	filtered_t term_new;
	filtered_t deriv;
	filtered_t deriv_neg;

	// steepest falling and rising slopes in the current window
	filtered_t fall_peak;
	filtered_t rise_peak;
	nibble_t reset_phase;

	always_ff @(posedge adc_clk)
	begin
		prev_4 <= prev_3;
		prev_3 <= prev_2;
		prev_2 <= prev_1;
		prev_1 <= adc_d;
	end

	// ------------------------------
	// derivative filter
	// ------------------------------
	// 2*x[-4] + x[-3] - x[-1] - 2*x[0], positive on a falling carrier
	assign term_old = filtered_t'({2'b00, prev_4, 1'b0}) + filtered_t'({3'b000, prev_3});
	assign term_new = filtered_t'({3'b000, prev_1}) + filtered_t'({2'b00, adc_d, 1'b0});
	assign deriv = term_old - term_new;
	assign deriv_neg = -deriv;

	// ------------------------------
	// peak hold and decision
	// ------------------------------
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			fall_peak <= '0;
			rise_peak <= '0;
			tag_bit <= 1'b0;
		end
		else if (tick[3:0] == reset_phase)
		begin
			// modulation needs a falling and a rising edge, any order
			tag_bit <= (fall_peak > slope_th) && (rise_peak > slope_th);
			fall_peak <= '0;
			rise_peak <= '0;
		end
		else if (deriv > 0)
		begin
			if (deriv > fall_peak)
				fall_peak <= deriv;
		end
		else if (deriv_neg > rise_peak)
		begin
			rise_peak <= deriv_neg;
		end
	end

	// tag answers a fixed delay after the end of the reader pause
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			reset_phase <= '0;
		else if (rf_status.reader_rise && rf_status.deep_mod)
			reset_phase <= tick[3:0] - detect_offset;
	end

endmodule

/* carrier_timebase.sv */
/*
 * 128-tick timebase locked to the reader bit phase.
 * Correction only runs during deep modulation, one step per reader edge.
 */
module carrier_timebase
	import iso14443a_rf_pkg::*;
	import sniff_frame_pkg::*;
(
	input logic adc_clk,
	input logic fdt_reset,
	input rf_status_t rf_status,
	output tick_t tick
);

	// low nibble of the last reader falling edge
	nibble_t fall_phase;
	logic warp_now;

	assign warp_now = rf_status.deep_mod && (tick[3:0] == warp_phase);

	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			tick <= '0;
			fall_phase <= edge_invalid;
		end
		else
		begin
			if (rf_status.reader_fall)
				fall_phase <= tick[3:0];

			if (warp_now)
			begin
				// edge just after sampling, move the sample point earlier
				if (fall_phase == 4'd1)
					tick <= tick + 7'd2;
				// edge just before sampling, wait one tick
				else if (fall_phase == 4'd0)
					tick <= tick;
				else
					tick <= tick + 7'd1;
				// one correction per detected edge
				fall_phase <= edge_invalid;
			end
			else
			begin
				// 127 wraps to 0 by width
				tick <= tick + 7'd1;
			end
		end
	end

endmodule

/* carrier_frontend.sv */
/*
 * Reader signal shaping for the sniffer. Assumes 100% ASK from the reader.
 * Field loss forces reader_bit high after field_loss_ticks of weak carrier.
 */
module carrier_frontend
	import iso14443a_rf_pkg::*;
(
	input logic adc_clk,
	input logic fdt_reset,
	input adc_sample_t adc_d,
	output rf_status_t rf_status
);

	localparam int loss_w = $clog2(field_loss_ticks);
	localparam int zero_w = $clog2(deep_zero_ticks);
	localparam int idle_w = $clog2(deep_idle_ticks);

	logic [loss_w-1:0] low_cnt;
	logic [zero_w-1:0] zero_cnt;
	logic [idle_w-1:0] idle_cnt;
	logic bit_next;
	logic field_lost;

	// field missing for the full window
	assign field_lost = (adc_d < field_on_th) && (low_cnt == loss_w'(field_loss_ticks - 1));

	// ------------------------------
	// schmitt trigger
	// ------------------------------
	always_comb
	begin
		// hold the level between the thresholds
		bit_next = rf_status.reader_bit;
		if (adc_d >= hyst_high_th)
		begin
			bit_next = 1'b1;
		end
		else if (adc_d < hyst_low_th)
		begin
			bit_next = 1'b0;
		end
		// no field looks like an unmodulated carrier
		if (field_lost)
		begin
			bit_next = 1'b1;
		end
	end

	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			rf_status <= '{reader_bit: 1'b1, default: 1'b0};
			low_cnt <= '0;
			zero_cnt <= '0;
			idle_cnt <= '0;
		end
		else
		begin
			rf_status.reader_bit <= bit_next;
			// edge flags line up with the new reader_bit
			rf_status.reader_rise <= bit_next & ~rf_status.reader_bit;
			rf_status.reader_fall <= ~bit_next & rf_status.reader_bit;

			// field loss window, restarts after it fires
			if (adc_d >= field_on_th || field_lost)
				low_cnt <= '0;
			else
				low_cnt <= low_cnt + 1'b1;

			// deep modulation, entered on a zero run
			if (adc_d == '0)
			begin
				if (zero_cnt == zero_w'(deep_zero_ticks - 1))
				begin
					rf_status.deep_mod <= 1'b1;
					idle_cnt <= '0;
				end
				else
					zero_cnt <= zero_cnt + 1'b1;
			end
			else
			begin
				zero_cnt <= '0;
				// long carrier means the reader waits for the tag
				if (idle_cnt == idle_w'(deep_idle_ticks - 1))
					rf_status.deep_mod <= 1'b0;
				else
					idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

endmodule

/* sniff_frame_pkg.sv */
/*
 * Timebase, byte packing and SSP framing definitions.
 * One 128-tick period carries one byte; ssp_clk is adc_clk / 8.
 */
package sniff_frame_pkg;

	// 0..127 position inside the byte period
	typedef logic [6:0] tick_t;

	typedef logic [3:0] nibble_t;

	// byte sent to the host, reader bits in the upper half
	typedef struct packed {
		nibble_t reader_nib;
		nibble_t tag_nib;
	} sniff_byte_t;

	// ------------------------------
	// timebase phases
	// ------------------------------

	// low nibble where the reader phase correction is done
	localparam nibble_t warp_phase = 4'd13;
	// low nibble where reader and tag bits are sampled
	localparam nibble_t sample_phase = 4'd0;
	localparam tick_t load_tick = 7'd127;

	// no reader falling edge pending
	localparam nibble_t edge_invalid = 4'd8;

	// ------------------------------
	// ssp framing
	// ------------------------------

	localparam int bit_ticks = 8;
	localparam int frame_ticks = 64;
	localparam int frame_high_ticks = 8;

endpackage

/* iso14443a_rf_pkg.sv */
/*
 * Carrier sample and demodulation definitions for the ISO14443-A sniffer.
 * Thresholds assume the 8-bit ADC runs at the 13.56 MHz carrier rate.
 */
package iso14443a_rf_pkg;

	// ------------------------------
	// sample and filter words
	// ------------------------------

	// raw carrier amplitude from the ADC, unsigned
	typedef logic [7:0] adc_sample_t;

	// derivative filter output, range about +-765
	typedef logic signed [10:0] filtered_t;

	// ------------------------------
	// reader demodulation
	// ------------------------------

	// schmitt trigger levels, about 1.14 V and 1.04 V at the ADC input
	localparam adc_sample_t hyst_high_th = 8'd16;
	localparam adc_sample_t hyst_low_th = 8'd8;

	// below this the reader field counts as missing
	localparam adc_sample_t field_on_th = 8'd192;
	localparam int field_loss_ticks = 4096;

	// zero run that means the reader pauses the carrier
	localparam int deep_zero_ticks = 8;
	// nonzero run after which the reader is taken as idle
	localparam int deep_idle_ticks = 256;

	// ------------------------------
	// tag load modulation
	// ------------------------------

	// both slope peaks must exceed this for a modulated bit
	localparam filtered_t slope_th = 11'sd5;
	// detector reset sits this many ticks before the reader rising edge phase
	localparam logic [3:0] detect_offset = 4'd4;

	// demodulated state, shared by all consumers
	typedef struct packed {
		logic reader_bit;
		logic deep_mod;
		logic reader_rise;
		logic reader_fall;
	} rf_status_t;

endpackage
